/* Makefile */
OBJ_DIR = obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module tb_fetch -f project.f \
		--Mdir $(OBJ_DIR) -o sim_tb_fetch

run: compile
	./$(OBJ_DIR)/sim_tb_fetch

clean:
	rm -rf $(OBJ_DIR)

/* fetch_patterns.txt */
// One step per line, every field in hex
// count redirect target flush stall_percent total_fetched total_misses
8  1 00001000 0 00 08 02
8  1 00001000 0 1E 10 02
C  1 00001000 1 32 1C 03
8  1 00002000 0 14 24 05
4  1 00001000 0 00 28 06
8  1 00100000 0 0A 30 07
2  1 00100000 0 00 32 09
1  1 00001010 0 19 33 0A
6  0 00000000 0 28 39 0B
4  0 00000000 0 3C 3D 0C
28 1 00001038 0 23 65 16
28 0 00000000 0 2D 8D 16

/* fetch_perf.sv */
`timescale 1ns/1ps

module fetch_perf
    import fetch_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    input  logic  fetched,
    input  logic  hit,
    input  logic  miss,
    output perf_t counts
);

    // Stick at all ones instead of wrapping
    function automatic logic [31:0] sat_inc(input logic [31:0] value);
        logic [31:0] result;
        if (&value) begin
            result = value;
        end else begin
            result = value + 32'd1;
        end
        return result;
    endfunction

    // ----------------------------------------------------------------------
    // Event counters
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            counts <= '0;
        end else begin
            if (fetched) begin
                counts.fetched <= sat_inc(counts.fetched);
            end
            if (hit) begin
                counts.hits <= sat_inc(counts.hits);
            end
            if (miss) begin
                counts.misses <= sat_inc(counts.misses);
            end
        end
    end

endmodule

/* fetch_pkg.sv */
package fetch_pkg;

    // ----------------------------------------------------------------------
    // Fetch path geometry
    // ----------------------------------------------------------------------
    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = 32'h0000_1000;

    localparam int line_words = 4;
    localparam int num_lines = 16;

    // Address split: tag | index | word offset | byte
    localparam int byte_bits = 2;
    localparam int offset_bits = $clog2(line_words);
    localparam int index_bits = $clog2(num_lines);
    localparam int line_lsb = byte_bits + offset_bits;
    localparam int tag_bits = xlen - index_bits - line_lsb;

    // Refill burst as seen on AR
    localparam logic [7:0] axi_len_line = 8'(line_words - 1);
    localparam logic [2:0] axi_size_word = 3'd2;
    localparam logic [1:0] axi_burst_incr = 2'b01;
    localparam logic [3:0] axi_id_fetch = 4'd0;

    // ----------------------------------------------------------------------
    // Encodings
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } axi_resp_e;

    typedef enum logic [2:0] {
        cs_idle,
        cs_lookup,
        cs_refill_addr,
        cs_refill_data,
        cs_flush
    } cache_state_e;

    // ----------------------------------------------------------------------
    // Bundles
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [xlen-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic [xlen-1:0] instr;
        logic            fault;
    } fetch_rsp_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
        logic            fault;
    } fetch_out_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [3:0]      id;
        logic [7:0]      len;
        logic [2:0]      size;
        logic [1:0]      burst;
    } axi_ar_t;

    typedef struct packed {
        logic [xlen-1:0] data;
        axi_resp_e       resp;
        logic            last;
        logic [3:0]      id;
    } axi_r_t;

    typedef struct packed {
        logic [31:0] fetched;
        logic [31:0] hits;
        logic [31:0] misses;
    } perf_t;

endpackage

/* fetch_top.sv */
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic       clock,
    input  logic       reset,

    // Decode side
    output logic       out_valid,
    input  logic       out_ready,
    output fetch_out_t out,
    input  redirect_t  redirect,
    input  logic       flush,

    // Memory side
    output logic       ar_valid,
    input  logic       ar_ready,
    output axi_ar_t    ar,
    input  logic       r_valid,
    output logic       r_ready,
    input  axi_r_t     r,

    output perf_t      counts
);

    logic       req_valid;
    logic       req_ready;
    fetch_req_t req;
    logic       rsp_valid;
    fetch_rsp_t rsp;
    logic       hit;
    logic       miss;
    logic       fetched;

    // One instruction handed to decode
    assign fetched = out_valid && out_ready;

    fetch_unit u_fetch_unit (
        .clock     (clock),
        .reset     (reset),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out),
        .redirect  (redirect),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    icache u_icache (
        .clock     (clock),
        .reset     (reset),
        .flush     (flush),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .ar        (ar),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .r         (r),
        .hit       (hit),
        .miss      (miss)
    );

    fetch_perf u_fetch_perf (
        .clock   (clock),
        .reset   (reset),
        .fetched (fetched),
        .hit     (hit),
        .miss    (miss),
        .counts  (counts)
    );

endmodule

/* fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
    import fetch_pkg::*;
(
    input  logic       clock,
    input  logic       reset,

    // Toward decode
    output logic       out_valid,
    input  logic       out_ready,
    output fetch_out_t out,
    input  redirect_t  redirect,

    // Toward the instruction cache
    output logic       req_valid,
    input  logic       req_ready,
    output fetch_req_t req,
    input  logic       rsp_valid,
    input  fetch_rsp_t rsp
);

    logic [xlen-1:0] pc;
    logic            started;
    logic            transfer;
    logic [xlen-1:0] next_pc;

    assign transfer = out_valid && out_ready;

    // Redirect only matters at the transfer edge
    always_comb begin
        if (redirect.taken) begin
            next_pc = redirect.target;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    // The cache sees the current pc directly
    assign req.addr = pc;

    // ----------------------------------------------------------------------
    // PC and request control
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc        <= reset_pc;
            started   <= 1'b0;
            req_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            started <= 1'b1;

            // First fetch right after reset, then one per transfer
            if (!started) begin
                req_valid <= 1'b1;
            end else if (transfer) begin
                req_valid <= 1'b1;
            end else if (req_valid && req_ready) begin
                req_valid <= 1'b0;
            end

            if (rsp_valid) begin
                out_valid <= 1'b1;
            end else if (transfer) begin
                out_valid <= 1'b0;
            end

            if (transfer) begin
                pc <= next_pc;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Output register toward decode
    // ----------------------------------------------------------------------
    // Only loaded on a response; one request outstanding keeps it stable
    always_ff @(posedge clock) begin
        if (rsp_valid) begin
            out.pc    <= pc;
            out.instr <= rsp.instr;
            out.fault <= rsp.fault;
        end
    end

endmodule

/* icache.sv */
`timescale 1ns/1ps

module icache
    import fetch_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       flush,

    // Fetch side
    input  logic       req_valid,
    output logic       req_ready,
    input  fetch_req_t req,
    output logic       rsp_valid,
    output fetch_rsp_t rsp,

    // AXI4 read channels
    output logic       ar_valid,
    input  logic       ar_ready,
    output axi_ar_t    ar,
    input  logic       r_valid,
    output logic       r_ready,
    input  axi_r_t     r,

    // Event pulses
    output logic       hit,
    output logic       miss
);

    cache_state_e state;
    logic         flush_pending;

    // Storage
    logic [num_lines-1:0] line_valid;
    logic [tag_bits-1:0]  tag_mem [num_lines];
    logic [xlen-1:0]      data_mem [num_lines][line_words];

    // Current request
    logic [xlen-1:0]        addr_q;
    logic [tag_bits-1:0]    addr_tag;
    logic [index_bits-1:0]  addr_index;
    logic [offset_bits-1:0] addr_offset;
    logic                   lookup_hit;

    // Refill bookkeeping
    logic [offset_bits-1:0] beat;
    logic                   beat_err;
    logic                   refill_err;
    logic                   rsp_done;
    fetch_rsp_t             rsp_q;

    assign addr_tag    = addr_q[xlen-1:line_lsb + index_bits];
    assign addr_index  = addr_q[line_lsb + index_bits - 1:line_lsb];
    assign addr_offset = addr_q[line_lsb - 1:byte_bits];

    assign lookup_hit = line_valid[addr_index] && (tag_mem[addr_index] == addr_tag);

    assign hit  = (state == cs_lookup) && lookup_hit;
    assign miss = (state == cs_lookup) && !lookup_hit;

    // A pending flush takes the idle slot before any new request
    assign req_ready = (state == cs_idle) && !flush_pending;
    assign rsp_valid = hit || rsp_done;

    always_comb begin
        if (rsp_done) begin
            rsp = rsp_q;
        end else begin
            rsp.instr = data_mem[addr_index][addr_offset];
            rsp.fault = 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    // AXI read burst for one line
    // ----------------------------------------------------------------------
    assign ar_valid = (state == cs_refill_addr);
    assign r_ready  = (state == cs_refill_data);

    always_comb begin
        ar.addr  = {addr_q[xlen-1:line_lsb], {line_lsb{1'b0}}};
        ar.id    = axi_id_fetch;
        ar.len   = axi_len_line;
        ar.size  = axi_size_word;
        ar.burst = axi_burst_incr;
    end

    // Error response or a stray id both poison the line
    assign beat_err = (r.resp != resp_okay) || (r.id != axi_id_fetch);

    // ----------------------------------------------------------------------
    // Controller
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state         <= cs_idle;
            flush_pending <= 1'b0;
            line_valid    <= '0;
            beat          <= '0;
            refill_err    <= 1'b0;
            rsp_done      <= 1'b0;
        end else begin
            rsp_done <= 1'b0;
            if (flush) begin
                flush_pending <= 1'b1;
            end

            case (state)
                cs_idle: begin
                    if (flush_pending) begin
                        state <= cs_flush;
                    end else if (req_valid) begin
                        state <= cs_lookup;
                    end
                end
                cs_lookup: begin
                    if (lookup_hit) begin
                        state <= cs_idle;
                    end else begin
                        state <= cs_refill_addr;
                    end
                end
                cs_refill_addr: begin
                    if (ar_ready) begin
                        beat       <= '0;
                        refill_err <= 1'b0;
                        state      <= cs_refill_data;
                    end
                end
                cs_refill_data: begin
                    if (r_valid) begin
                        beat <= beat + 1'b1;
                        if (beat_err) begin
                            refill_err <= 1'b1;
                        end
                        if (r.last) begin
                            line_valid[addr_index] <= !(refill_err || beat_err);
                            rsp_done               <= 1'b1;
                            state                  <= cs_idle;
                        end
                    end
                end
                cs_flush: begin
                    // A pulse landing here stays pending for the next round
                    line_valid    <= '0;
                    flush_pending <= flush;
                    state         <= cs_idle;
                end
                default: state <= cs_idle;
            endcase
        end
    end

    // Arrays and the miss response
    always_ff @(posedge clock) begin
        if (req_valid && req_ready) begin
            addr_q <= req.addr;
        end
        if ((state == cs_refill_data) && r_valid) begin
            data_mem[addr_index][beat] <= r.data;
            if (beat == addr_offset) begin
                rsp_q.instr <= r.data;
            end
            if (r.last) begin
                tag_mem[addr_index] <= addr_tag;
                rsp_q.fault         <= refill_err || beat_err;
            end
        end
    end

endmodule

/* project.f */
fetch_pkg.sv
fetch_unit.sv
icache.sv
fetch_perf.sv
fetch_top.sv
tb_fetch_props.sv
tb_fetch.sv

/* tb_fetch.sv */
`timescale 1ns/1ps

module tb_fetch
    import fetch_pkg::*;
();

    localparam int step_words = 7;
    localparam int max_steps = 32;
    localparam int cycles_per_step = 2000;
    localparam logic [31:0] lcg_seed = 32'hdbd7;
    localparam logic [31:0] slverr_base = 32'h0010_0000;

    logic       clock;
    logic       reset;
    logic       out_valid;
    logic       out_ready;
    fetch_out_t out;
    redirect_t  redirect;
    logic       flush;
    logic       ar_valid;
    logic       ar_ready;
    axi_ar_t    ar;
    logic       r_valid;
    logic       r_ready;
    axi_r_t     r;
    perf_t      counts;

    logic [31:0] pattern_mem [max_steps * step_words];
    int          num_steps;

    // Reference model of the cache tags and the counters
    logic        model_valid [num_lines];
    logic [23:0] model_tag [num_lines];
    perf_t       model_counts;

    fetch_top dut (
        .clock     (clock),
        .reset     (reset),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (out),
        .redirect  (redirect),
        .flush     (flush),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .ar        (ar),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .r         (r),
        .counts    (counts)
    );

    always #10 clock = ~clock;

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Low half is the address, high half its complement
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {~addr[15:0], addr[15:0]};
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_out(input string name, input fetch_out_t exp, input fetch_out_t act);
        if (act !== exp) begin
            fail_now($sformatf("Fail %s: expected %h/%h/%b, actual %h/%h/%b (pc/instr/fault)",
                name, exp.pc, exp.instr, exp.fault, act.pc, act.instr, act.fault));
        end
    endtask

    task automatic check_counts(input string name, input perf_t exp, input perf_t act);
        if (act !== exp) begin
            fail_now($sformatf({"Fail %s: expected %0d/%0d/%0d, ",
                "actual %0d/%0d/%0d (fetched/hits/misses)"},
                name, exp.fetched, exp.hits, exp.misses, act.fetched, act.hits, act.misses));
        end
    endtask

    // Index is pc[7:4], tag is pc[31:8]
    task automatic update_cache_model(input logic [31:0] pc);
        logic [3:0]  index;
        logic [23:0] tag;
        index = pc[7:4];
        tag = pc[31:8];
        if (model_valid[index] && model_tag[index] == tag) begin
            model_counts.hits = model_counts.hits + 32'd1;
        end else begin
            model_counts.misses = model_counts.misses + 32'd1;
            // Faulting refills leave the line empty
            model_valid[index] = (pc < slverr_base);
            model_tag[index] = tag;
        end
        model_counts.fetched = model_counts.fetched + 32'd1;
    endtask

    // ----------------------------------------------------------------------
    // AXI read memory with random latency
    // ----------------------------------------------------------------------
    initial begin : memory_model
        logic [31:0] seed;
        logic [31:0] base;
        logic        beat_taken;
        seed = lcg_seed;
        ar_ready = 1'b0;
        r_valid = 1'b0;
        r = '0;
        forever begin
            @(negedge clock);
            if (ar_valid) begin
                seed = lcg_next(seed);
                repeat (int'(seed[17:16])) @(negedge clock);
                base = ar.addr;
                ar_ready = 1'b1;
                @(negedge clock);
                ar_ready = 1'b0;
                for (int beat = 0; beat < 4; beat++) begin
                    seed = lcg_next(seed);
                    repeat (int'(seed[17:16]) % 3) @(negedge clock);
                    r.data = mem_word(base + 32'(beat * 4));
                    r.resp = (base >= slverr_base) ? resp_slverr : resp_okay;
                    r.last = (beat == 3);
                    r.id = 4'd0;
                    r_valid = 1'b1;
                    // Beat stays up until the cache takes it
                    beat_taken = 1'b0;
                    while (!beat_taken) begin
                        beat_taken = r_ready;
                        @(negedge clock);
                    end
                    r_valid = 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        @(negedge reset);
        repeat (num_steps * cycles_per_step) @(posedge clock);
        fail_now($sformatf("Timeout: the run did not finish within %0d cycles",
            num_steps * cycles_per_step));
    end

    // ----------------------------------------------------------------------
    // Decode model driven from the pattern file
    // ----------------------------------------------------------------------
    initial begin : stimulus
        int          count;
        int          accepted;
        int          stall_pct;
        int          base;
        logic        take;
        logic        do_flush;
        logic [31:0] target;
        logic [31:0] model_pc;
        logic [31:0] stall_seed;
        fetch_out_t  expected;
        perf_t       file_counts;
        string       name;

        clock = 1'b0;
        reset = 1'b1;
        out_ready = 1'b0;
        redirect = '0;
        flush = 1'b0;
        num_steps = 0;

        for (int i = 0; i < max_steps * step_words; i++) begin
            pattern_mem[i] = '0;
        end
        $readmemh("fetch_patterns.txt", pattern_mem);
        // A zero count ends the list
        while (num_steps < max_steps && pattern_mem[num_steps * step_words] != 32'd0) begin
            num_steps++;
        end
        if (num_steps == 0) begin
            fail_now("No stimulus steps could be read from fetch_patterns.txt");
        end

        for (int i = 0; i < num_lines; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i] = '0;
        end
        model_counts = '0;
        model_pc = reset_pc;
        stall_seed = lcg_next(lcg_seed);

        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        for (int step = 0; step < num_steps; step++) begin
            base = step * step_words;
            count = int'(pattern_mem[base]);
            take = pattern_mem[base + 1][0];
            target = pattern_mem[base + 2];
            do_flush = pattern_mem[base + 3][0];
            stall_pct = int'(pattern_mem[base + 4]);
            accepted = 0;

            while (accepted < count) begin
                @(negedge clock);
                redirect = '0;
                flush = 1'b0;
                stall_seed = lcg_next(stall_seed);
                out_ready = (int'(stall_seed[31:16]) % 100) >= stall_pct;
                if (out_valid && out_ready) begin
                    expected.pc = model_pc;
                    expected.instr = mem_word(model_pc);
                    expected.fault = (model_pc >= slverr_base);
                    name = $sformatf("step %0d instr %0d", step, accepted);
                    check_out(name, expected, out);
                    update_cache_model(model_pc);
                    accepted++;
                    // Redirect and flush ride on the last transfer of the step
                    if (accepted == count) begin
                        redirect.taken = take;
                        redirect.target = target;
                        flush = do_flush;
                    end
                    if (accepted == count && take) begin
                        model_pc = target;
                    end else begin
                        model_pc = model_pc + 32'd4;
                    end
                end
            end

            @(negedge clock);
            redirect = '0;
            flush = 1'b0;
            out_ready = 1'b0;
            if (do_flush) begin
                for (int i = 0; i < num_lines; i++) begin
                    model_valid[i] = 1'b0;
                end
            end

            file_counts.fetched = pattern_mem[base + 5];
            file_counts.misses = pattern_mem[base + 6];
            file_counts.hits = pattern_mem[base + 5] - pattern_mem[base + 6];
            check_counts($sformatf("step %0d counts vs model", step), model_counts, counts);
            check_counts($sformatf("step %0d counts vs pattern", step), file_counts, counts);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* tb_fetch_props.sv */
`timescale 1ns/1ps

module tb_fetch_props
    import fetch_pkg::*;
(
    input logic       clock,
    input logic       reset,
    input logic       out_valid,
    input logic       out_ready,
    input fetch_out_t out,
    input logic       ar_valid,
    input logic       ar_ready,
    input axi_ar_t    ar,
    input logic       r_ready
);

    // ----------------------------------------------------------------------
    // Handshake stability
    // ----------------------------------------------------------------------
    out_held: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && (out == $past(out)))
        else $error("out changed while decode stalled");

    ar_held: assert property (@(posedge clock) disable iff (reset)
        ar_valid && !ar_ready |=> ar_valid && (ar == $past(ar)))
        else $error("ar changed before ar_ready");

    // Four-beat incrementing word burst on a 16-byte line
    ar_shape: assert property (@(posedge clock) disable iff (reset)
        ar_valid |-> ar.len == 8'd3 && ar.addr[3:0] == 4'h0
            && ar.size == 3'd2 && ar.burst == 2'b01 && ar.id == 4'd0)
        else $error("ar burst is not one aligned cache line");

    reset_quiet: assert property (@(posedge clock)
        reset && $past(reset) |-> !out_valid && !ar_valid && !r_ready)
        else $error("handshake outputs active during reset");

endmodule

bind fetch_top tb_fetch_props props (
    .clock     (clock),
    .reset     (reset),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out       (out),
    .ar_valid  (ar_valid),
    .ar_ready  (ar_ready),
    .ar        (ar),
    .r_ready   (r_ready)
);
